//--- logic/cmt_config.svh
/* Commit stage widths and sizes */

`ifndef CMT_CONFIG_SVH
`define CMT_CONFIG_SVH

// Slots looked at per cycle at the ROB head
`define CMT_WIDTH       4

// Retire count, wide enough to hold CMT_WIDTH
`define CMT_CNT_W       3

`define CMT_PC_W        30 // Word address
`define CMT_DW          64
`define CMT_PRF_AW      6  // 64 physical registers

// One-hot opcode buses of the long-operation unit
`define CMT_LSU_OPC_W   8
`define CMT_EPU_OPC_W   12

`define CMT_BTB_P_NUM   4  // PC bits dropped from the predictor tag

`endif

//--- logic/cmt_types_pkg.sv
/* ROB slot and predictor types */

`include "cmt_config.svh"

package cmt_types_pkg;

   // One entry at the head of the reorder buffer
   typedef struct packed {
      logic                       valid;
      logic [`CMT_PC_W-1:0]       pc;
      logic [`CMT_LSU_OPC_W-1:0]  lsu_opc;
      logic [`CMT_EPU_OPC_W-1:0]  epu_opc;
      logic                       exc;      // Raised exception, handled as EPU op
      logic                       fls;      // Mispredicted
      logic [`CMT_PC_W-1:0]       fls_tgt;  // Correct target
      logic                       is_bcc;
      logic                       is_brel;
      logic                       is_breg;
      logic                       bpu_taken;
      logic [`CMT_PC_W-1:0]       bpu_tgt;
      logic [`CMT_PRF_AW-1:0]     prd;
      logic                       prd_we;
      logic [`CMT_DW-1:0]         opera;
      logic [`CMT_DW-1:0]         operb;
   } cmt_slot_t;

   typedef cmt_slot_t [`CMT_WIDTH-1:0] cmt_slot_vec_t;

   typedef logic [`CMT_WIDTH-1:0] cmt_fire_t;

   // Training record for the branch predictor
   typedef struct packed {
      logic                                  wb;
      logic                                  is_bcc;
      logic                                  is_breg;
      logic                                  is_brel;
      logic                                  taken;   // Actual direction
      logic [`CMT_PC_W-1:`CMT_BTB_P_NUM]     pc_tag;
      logic [`CMT_PC_W-1:0]                  npc_act; // Actual next PC
   } bpu_upd_t;

   // Physical register file write port
   typedef struct packed {
      logic                       we;
      logic [`CMT_PRF_AW-1:0]     waddr;
      logic [`CMT_DW-1:0]         wdata;
   } prf_wr_t;

endpackage

//--- logic/cmt_fu_pkg.sv
/* Long-operation unit interface types */

`include "cmt_config.svh"

package cmt_fu_pkg;

   // Request from slot 0 to the LSU/EPU
   typedef struct packed {
      logic                       valid;
      logic                       is_epu;   // Low means plain load/store
      logic [`CMT_PC_W-1:0]       pc;
      logic [`CMT_LSU_OPC_W-1:0]  lsu_opc;
      logic [`CMT_EPU_OPC_W-1:0]  epu_opc;
      logic [`CMT_DW-1:0]         opera;    // Address or operand
      logic [`CMT_DW-1:0]         operb;    // Store data or operand
   } fu_req_t;

   // Completion from the LSU/EPU
   typedef struct packed {
      logic                       done;     // One pulse per request
      logic [`CMT_DW-1:0]         wdata;
      logic                       exc_flush;
      logic [`CMT_PC_W-1:0]       exc_tgt;
      logic                       refetch;  // Retire, then restart at pc+1
   } fu_rsp_t;

endpackage

//--- logic/cmt_select.sv
/* Commit slot selection */

`timescale 1ns/10ps

`include "cmt_config.svh"

module cmt_select
(
   input  cmt_types_pkg::cmt_slot_vec_t   rob_head,
   input  logic                           se_pending,
   input  logic                           flush,
   input  logic                           commit_en,
   output cmt_types_pkg::cmt_fire_t       fire,
   output logic [`CMT_CNT_W-1:0]          pop_size,
   output logic                           slot0_long,
   output logic                           slot0_is_epu
);
   import cmt_types_pkg::*;

   cmt_fire_t valid;
   cmt_fire_t branch;
   cmt_fire_t epu_op;
   cmt_fire_t long_op;
   cmt_fire_t single;
   cmt_fire_t mask;
   cmt_fire_t ready;

   // Per-slot classification
   always_comb
   begin
      for (int i = 0; i < `CMT_WIDTH; i++)
      begin
         valid[i]   = rob_head[i].valid;
         branch[i]  = rob_head[i].is_bcc | rob_head[i].is_brel | rob_head[i].is_breg;
         epu_op[i]  = (|rob_head[i].epu_opc) | rob_head[i].exc;
         // Nothing goes out to the unit while a redirect is in flight
         long_op[i] = ~se_pending & ((|rob_head[i].lsu_opc) | epu_op[i]);
         single[i]  = long_op[i] | rob_head[i].fls | branch[i];
      end
   end

   // In-order mask, a single-op slot must retire alone
   always_comb
   begin
      mask[0] = 1'b1;
      mask[1] = ~single[0] & ~single[1];
      for (int j = 2; j < `CMT_WIDTH; j++)
      begin
         mask[j] = mask[j-1] & ~single[j];
      end
   end

   assign ready = valid & mask; // Holes do not break the run

   assign fire = ready & {`CMT_WIDTH{commit_en & ~flush}};

   always_comb
   begin
      pop_size = '0;
      for (int k = 0; k < `CMT_WIDTH; k++)
      begin
         pop_size = pop_size + `CMT_CNT_W'(fire[k]);
      end
   end

   // Slot 0 wants the long-operation unit
   assign slot0_long   = ready[0] & long_op[0];
   assign slot0_is_epu = epu_op[0];

endmodule

//--- logic/cmt_redirect.sv
/* Flush and predictor update */

`timescale 1ns/10ps

`include "cmt_config.svh"

module cmt_redirect
(
   input  logic                           clk,
   input  logic                           rst,
   input  cmt_types_pkg::cmt_slot_vec_t   rob_head,
   input  cmt_types_pkg::cmt_fire_t       fire,
   input  cmt_fu_pkg::fu_rsp_t            fu_rsp,
   output logic                           flush,
   output logic [`CMT_PC_W-1:0]           flush_tgt,
   output logic                           se_pending,
   output cmt_types_pkg::bpu_upd_t        bpu_upd
);
   import cmt_types_pkg::*;

   cmt_slot_t                 s0;
   logic                      s0_branch;
   logic [`CMT_PC_W-1:0]      npc0;
   logic                      se_set;
   logic [`CMT_PC_W-1:0]      se_tgt_nxt;
   logic [`CMT_PC_W-1:0]      se_tgt;

   assign s0        = rob_head[0];
   assign s0_branch = s0.is_bcc | s0.is_brel | s0.is_breg;
   assign npc0      = s0.pc + `CMT_PC_W'(1);

   // Sequential flush, raised by a retiring slot 0
   assign se_set     = fire[0] & (s0.fls | fu_rsp.refetch);
   assign se_tgt_nxt = s0.fls ? s0.fls_tgt : npc0; // Refetch restarts after slot 0

   // No slot fires during the flush, so the flag drops after one cycle
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         se_pending <= 1'b0;
      end
      else
      begin
         se_pending <= se_set;
      end
   end

   always_ff @(posedge clk)
   begin
      if (fire[0])
      begin
         se_tgt <= se_tgt_nxt;
      end
   end

   // Registered flush wins over an exception from the unit
   assign flush     = se_pending | fu_rsp.exc_flush;
   assign flush_tgt = se_pending ? se_tgt : fu_rsp.exc_tgt;

   // Predictor training from slot 0 only
   always_comb
   begin
      bpu_upd.wb      = fire[0] & s0_branch;
      bpu_upd.is_bcc  = s0.is_bcc;
      bpu_upd.is_breg = s0.is_breg;
      bpu_upd.is_brel = s0.is_brel;
      bpu_upd.taken   = s0.bpu_taken ^ s0.fls; // Misprediction flips the direction
      bpu_upd.pc_tag  = s0.pc[`CMT_PC_W-1:`CMT_BTB_P_NUM];
      bpu_upd.npc_act = s0.fls ? s0.fls_tgt : s0.bpu_tgt;
   end

endmodule

//--- logic/cmt_longop.sv
/* Long-operation tracking */

`timescale 1ns/10ps

`include "cmt_config.svh"

module cmt_longop
(
   input  logic                           clk,
   input  logic                           rst,
   input  cmt_types_pkg::cmt_slot_vec_t   rob_head,
   input  logic                           slot0_long,
   input  logic                           slot0_is_epu,
   input  logic                           flush,
   input  cmt_fu_pkg::fu_rsp_t            fu_rsp,
   output cmt_fu_pkg::fu_req_t            fu_req,
   output logic                           commit_en,
   output cmt_types_pkg::prf_wr_t         prf_wr
);
   import cmt_types_pkg::*;

   typedef enum logic [1:0]
   {
      S_IDLE    = 2'b01,
      S_PENDING = 2'b10
   } state_t;

   state_t        state_q;
   state_t        state_d;
   cmt_slot_t     s0;
   logic          issue;

   assign s0    = rob_head[0];
   assign issue = (state_q == S_IDLE) & slot0_long & ~flush;

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         S_IDLE:
            if (issue)
               state_d = S_PENDING;
         S_PENDING:
            if (fu_rsp.done)
               state_d = S_IDLE;
         default:
            state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state_q <= S_IDLE;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   // Request carries slot 0 as it sits at the head
   always_comb
   begin
      fu_req.valid   = issue;
      fu_req.is_epu  = slot0_is_epu;
      fu_req.pc      = s0.pc;
      fu_req.lsu_opc = s0.lsu_opc;
      fu_req.epu_opc = s0.epu_opc;
      fu_req.opera   = s0.opera;
      fu_req.operb   = s0.operb;
   end

   // Hold retirement until the unit finishes
   assign commit_en = ~slot0_long | fu_rsp.done;

   always_comb
   begin
      prf_wr.we    = (state_q == S_PENDING) & fu_rsp.done & s0.prd_we & ~flush;
      prf_wr.waddr = s0.prd;
      prf_wr.wdata = fu_rsp.wdata;
   end

endmodule

//--- logic/cmt_top.sv
/* Commit stage top level */

`timescale 1ns/10ps

`include "cmt_config.svh"

module cmt_top
(
   input  logic                           clk,
   input  logic                           rst,
   // From ROB
   input  cmt_types_pkg::cmt_slot_vec_t   rob_head,
   // To ROB
   output cmt_types_pkg::cmt_fire_t       cmt_fire,
   output logic [`CMT_CNT_W-1:0]          cmt_pop_size,
   // Pipeline redirect
   output logic                           flush,
   output logic [`CMT_PC_W-1:0]           flush_tgt,
   // To branch predictor
   output cmt_types_pkg::bpu_upd_t        bpu_upd,
   // Long-operation unit
   output cmt_fu_pkg::fu_req_t            fu_req,
   input  cmt_fu_pkg::fu_rsp_t            fu_rsp,
   // To register file
   output cmt_types_pkg::prf_wr_t         prf_wr
);

   logic          se_pending;
   logic          commit_en;
   logic          slot0_long;
   logic          slot0_is_epu;

   cmt_select u_select
   (
      .rob_head      (rob_head),
      .se_pending    (se_pending),
      .flush         (flush),
      .commit_en     (commit_en),
      .fire          (cmt_fire),
      .pop_size      (cmt_pop_size),
      .slot0_long    (slot0_long),
      .slot0_is_epu  (slot0_is_epu)
   );

   cmt_redirect u_redirect
   (
      .clk           (clk),
      .rst           (rst),
      .rob_head      (rob_head),
      .fire          (cmt_fire),
      .fu_rsp        (fu_rsp),
      .flush         (flush),
      .flush_tgt     (flush_tgt),
      .se_pending    (se_pending),
      .bpu_upd       (bpu_upd)
   );

   cmt_longop u_longop
   (
      .clk           (clk),
      .rst           (rst),
      .rob_head      (rob_head),
      .slot0_long    (slot0_long),
      .slot0_is_epu  (slot0_is_epu),
      .flush         (flush),
      .fu_rsp        (fu_rsp),
      .fu_req        (fu_req),
      .commit_en     (commit_en),
      .prf_wr        (prf_wr)
   );

endmodule

//--- tests/tb_clock.sv
/* Testbench clock and reset */

`timescale 1ns/10ps

module tb_clock
(
   output logic clk,
   output logic rst
);
   localparam real HALF_PERIOD = 2.0; // 4 ns clock

   initial
   begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   initial
   begin
      rst = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
   end

endmodule

//--- tests/cmt_assertions.sv
/* Commit stage bound checks */

`timescale 1ns/10ps

`include "cmt_config.svh"

module cmt_assertions
(
   input  logic                        clk,
   input  logic                        rst,
   input  cmt_types_pkg::cmt_fire_t    fire,
   input  logic [`CMT_CNT_W-1:0]       pop_size,
   input  logic                        flush,
   input  logic                        req_valid,
   input  logic                        rsp_done
);
   import cmt_types_pkg::*;

   logic pending; // Request out, done not seen yet

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pending <= 1'b0;
      end
      else if (rsp_done)
      begin
         pending <= 1'b0;
      end
      else if (req_valid)
      begin
         pending <= 1'b1;
      end
   end

   a_single_request: assert property (@(posedge clk) disable iff (rst) pending |-> !req_valid)
      else $error("Long-operation request issued while one is outstanding");

   a_done_expected: assert property (@(posedge clk) disable iff (rst) rsp_done |-> pending)
      else $error("Done pulse with no outstanding long-operation request");

   a_no_fire_flush: assert property (@(posedge clk) disable iff (rst) flush |-> fire == '0)
      else $error("Slot fired during a flush cycle");

   a_pop_count: assert property (@(posedge clk) disable iff (rst) pop_size == $countones(fire))
      else $error("Retire count does not match the fire vector");

endmodule

bind cmt_top cmt_assertions u_assertions
(
   .clk        (clk),
   .rst        (rst),
   .fire       (cmt_fire),
   .pop_size   (cmt_pop_size),
   .flush      (flush),
   .req_valid  (fu_req.valid),
   .rsp_done   (fu_rsp.done)
);

//--- tests/cmt_tb.sv
/* Commit stage testbench */

`timescale 1ns/10ps

`include "cmt_config.svh"

module cmt_tb;
   import cmt_types_pkg::*;
   import cmt_fu_pkg::*;

   logic                     clk;
   logic                     rst;
   cmt_slot_vec_t            rob_head;
   cmt_fire_t                cmt_fire;
   logic [`CMT_CNT_W-1:0]    cmt_pop_size;
   logic                     flush;
   logic [`CMT_PC_W-1:0]     flush_tgt;
   bpu_upd_t                 bpu_upd;
   fu_req_t                  fu_req;
   fu_rsp_t                  fu_rsp;
   prf_wr_t                  prf_wr;
   fu_rsp_t                  rsp_cfg;  // Returned with the next done pulse
   integer                   seed = 32'h0241_84d7;
   int                       errors = 0;
   int                       n;

   tb_clock u_clock (.clk(clk), .rst(rst));

   cmt_top u_dut (.*);

   // Long-operation unit model giving one done pulse 1 to 6 cycles after a request
   always
   begin
      int delay;
      @(negedge clk);
      if (!rst && fu_req.valid)
      begin
         delay = 1 + ($unsigned($random(seed)) % 6);
         repeat (delay) @(posedge clk);
         #1;
         fu_rsp      = rsp_cfg;
         fu_rsp.done = 1'b1;
         @(posedge clk);
         #1;
         fu_rsp = '0;
      end
   end

   task automatic compare_value
   (
      input string       name,
      input logic [63:0] got,
      input logic [63:0] exp
   );
      assert (got === exp)
      else
      begin
         $display("Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
         errors++;
      end
   endtask

   // Drive 1 ns after the rising edge and return at the falling edge for checks
   task automatic drive(input cmt_slot_vec_t head);
      @(posedge clk);
      #1;
      rob_head = head;
      @(negedge clk);
   endtask

   function automatic cmt_slot_t make_slot(input logic [`CMT_PC_W-1:0] pc);
      cmt_slot_t s;
      s        = '0;
      s.valid  = 1'b1;
      s.pc     = pc;
      s.prd    = pc[`CMT_PRF_AW-1:0];
      s.prd_we = 1'b1;
      s.opera  = {34'h2_0000_0000, pc};
      s.operb  = 64'hfeed_0000_0000_0000 | pc;
      return s;
   endfunction

   // Expected fire with nothing outstanding and no flush
   function automatic cmt_fire_t model_fire(input cmt_slot_vec_t head);
      cmt_fire_t f;
      logic      stop;
      logic      long_s;
      stop = 1'b0;
      for (int j = 0; j < `CMT_WIDTH; j++)
      begin
         long_s = (|head[j].lsu_opc) | (|head[j].epu_opc) | head[j].exc;
         stop   = stop | long_s | head[j].fls | head[j].is_bcc | head[j].is_brel | head[j].is_breg;
         f[j]   = head[j].valid & ((j == 0) ? ~long_s : ~stop); // Long slot 0 waits
      end
      return f;
   endfunction

   task automatic verify_retire(input cmt_fire_t exp);
      int cnt;
      cnt = 0;
      for (int k = 0; k < `CMT_WIDTH; k++)
         cnt += exp[k];
      compare_value("cmt_fire", cmt_fire, exp);
      compare_value("cmt_pop_size", cmt_pop_size, cnt);
   endtask

   // Issue slot 0 to the unit, then hold the head until done
   task automatic run_long(input cmt_slot_vec_t h);
      int cycles;
      cycles = 0;
      drive(h);
      compare_value("fu_req.valid", fu_req.valid, 1);
      compare_value("fu_req.is_epu", fu_req.is_epu, (|h[0].epu_opc) | h[0].exc);
      compare_value("fu_req.pc", fu_req.pc, h[0].pc);
      compare_value("fu_req.lsu_opc", fu_req.lsu_opc, h[0].lsu_opc);
      compare_value("fu_req.epu_opc", fu_req.epu_opc, h[0].epu_opc);
      compare_value("fu_req.opera", fu_req.opera, h[0].opera);
      compare_value("fu_req.operb", fu_req.operb, h[0].operb);
      verify_retire('0);
      while (!fu_rsp.done && cycles < 20)
      begin
         drive(h);
         cycles++;
         if (!fu_rsp.done)
         begin
            compare_value("fu_req.valid", fu_req.valid, 0);
            verify_retire('0);
         end
      end
      if (!fu_rsp.done)
      begin
         $display("Timeout: no done from the long-operation unit after %0d cycles", cycles);
         errors++;
      end
   endtask

   task automatic reset_defaults();
      int e;
      e = errors;
      drive('0);
      compare_value("flush", flush, 0);
      compare_value("fu_req.valid", fu_req.valid, 0);
      compare_value("prf_wr.we", prf_wr.we, 0);
      compare_value("bpu_upd.wb", bpu_upd.wb, 0);
      $display("reset_state: %0d errors", errors - e);
   endtask

   task automatic plain_retire();
      cmt_slot_vec_t h;
      int            e;
      e = errors;
      for (int i = 0; i < `CMT_WIDTH; i++)
         h[i] = make_slot(30'h100 + i);
      drive(h);
      verify_retire(model_fire(h));
      h[1].valid = 1'b0; // Hole does not stop slot 2
      drive(h);
      verify_retire(model_fire(h));
      compare_value("bpu_upd.wb", bpu_upd.wb, 0);
      $display("plain_retire: %0d errors", errors - e);
   endtask

   task automatic single_isolation();
      cmt_slot_vec_t h;
      int            e;
      e = errors;
      for (int j = 0; j < `CMT_WIDTH; j++)
      begin
         for (int i = 0; i < `CMT_WIDTH; i++)
            h[i] = make_slot(30'h200 + i);
         case (j)
            0: h[0].is_breg = 1'b1;
            1: h[1].is_bcc = 1'b1;
            2: h[2].fls = 1'b1;
            default: h[3].lsu_opc = 8'h01;
         endcase
         drive(h);
         verify_retire(model_fire(h));
      end
      $display("single_isolation: %0d errors", errors - e);
   endtask

   task automatic mispredict_redirect();
      cmt_slot_vec_t h;
      int            e;
      e = errors;
      h              = '0;
      h[0]           = make_slot(30'h300);
      h[0].is_bcc    = 1'b1;
      h[0].bpu_taken = 1'b0;
      h[0].bpu_tgt   = 30'h301;
      h[0].fls       = 1'b1;
      h[0].fls_tgt   = 30'h3c4; // Actually taken
      h[1]           = make_slot(30'h301);
      drive(h);
      verify_retire(4'b0001);
      compare_value("bpu_upd.wb", bpu_upd.wb, 1);
      compare_value("bpu_upd.is_bcc", bpu_upd.is_bcc, 1);
      compare_value("bpu_upd.is_breg", bpu_upd.is_breg, 0);
      compare_value("bpu_upd.is_brel", bpu_upd.is_brel, 0);
      compare_value("bpu_upd.taken", bpu_upd.taken, !h[0].bpu_taken);
      compare_value("bpu_upd.npc_act", bpu_upd.npc_act, h[0].fls_tgt);
      compare_value("bpu_upd.pc_tag", bpu_upd.pc_tag, 26'h30);
      h    = '0;
      h[0] = make_slot(30'h3c4);
      drive(h);
      compare_value("flush", flush, 1);
      compare_value("flush_tgt", flush_tgt, 30'h3c4);
      verify_retire('0);
      drive(h);
      compare_value("flush", flush, 0);
      $display("mispredict: %0d errors", errors - e);
   endtask

   task automatic long_op_writeback();
      cmt_slot_vec_t h;
      int            e;
      e = errors;
      h               = '0;
      h[0]            = make_slot(30'h400);
      h[0].lsu_opc    = 8'h02;
      h[0].prd        = 6'h2a;
      h[1]            = make_slot(30'h401);
      rsp_cfg         = '0;
      rsp_cfg.wdata   = 64'h1234_5678_9abc_def0;
      run_long(h);
      verify_retire(4'b0001); // Slot 0 retires alone
      compare_value("prf_wr.we", prf_wr.we, 1);
      compare_value("prf_wr.waddr", prf_wr.waddr, h[0].prd);
      compare_value("prf_wr.wdata", prf_wr.wdata, rsp_cfg.wdata);
      drive('0);
      $display("long_op: %0d errors", errors - e);
   endtask

   task automatic exception_flush();
      cmt_slot_vec_t h;
      int            e;
      e = errors;
      h                 = '0;
      h[0]              = make_slot(30'h500);
      h[0].epu_opc      = 12'h010;
      rsp_cfg           = '0;
      rsp_cfg.exc_flush = 1'b1;
      rsp_cfg.exc_tgt   = 30'h0bf0;
      run_long(h);
      compare_value("flush", flush, 1);
      compare_value("flush_tgt", flush_tgt, rsp_cfg.exc_tgt);
      verify_retire('0);
      compare_value("prf_wr.we", prf_wr.we, 0);
      drive('0);
      compare_value("flush", flush, 0);
      $display("exception: %0d errors", errors - e);
   endtask

   task automatic refetch_flush();
      cmt_slot_vec_t h;
      int            e;
      e = errors;
      h               = '0;
      h[0]            = make_slot(30'h600);
      h[0].epu_opc    = 12'h004;
      rsp_cfg         = '0;
      rsp_cfg.refetch = 1'b1;
      rsp_cfg.wdata   = 64'h0000_0000_cafe_0600;
      run_long(h);
      verify_retire(4'b0001);
      compare_value("prf_wr.we", prf_wr.we, 1);
      h    = '0;
      h[0] = make_slot(30'h601);
      drive(h);
      compare_value("flush", flush, 1);
      compare_value("flush_tgt", flush_tgt, 30'h601);
      verify_retire('0);
      drive('0);
      compare_value("flush", flush, 0);
      $display("refetch: %0d errors", errors - e);
   endtask

   initial
   begin
      rob_head = '0;
      fu_rsp   = '0;
      rsp_cfg  = '0;
      n        = 0;
      while (rst !== 1'b0 && n < 20)
      begin
         @(posedge clk);
         n++;
      end
      if (rst !== 1'b0)
      begin
         $display("Reset never released");
         errors++;
      end
      reset_defaults();
      plain_retire();
      single_isolation();
      mispredict_redirect();
      long_op_writeback();
      exception_flush();
      refetch_flush();
      $display("Tests run: 7, errors: %0d", errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

//--- src.f
+incdir+logic
logic/cmt_types_pkg.sv
logic/cmt_fu_pkg.sv
logic/cmt_select.sv
logic/cmt_redirect.sv
logic/cmt_longop.sv
logic/cmt_top.sv
tests/tb_clock.sv
tests/cmt_assertions.sv
tests/cmt_tb.sv
